// ==== core.f ====
design/core_pkg.sv
design/alu32.sv
design/register_file.sv
design/instruction_decoder.sv
design/instruction_sequencer.sv
design/load_store_unit.sv
design/memory_arbiter.sv
design/shared_memory.sv
design/core_top.sv
test/core_assertions.sv
test/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module core_tb -Mdir obj_dir -f core.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/Vcore_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Result: FAILED" sim.log; then
  exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi

exit 0

// ==== test/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

  localparam int data_base  = 512;
  localparam int data_words = 8;
  localparam int stop_at    = 15;

  logic        clock = 1'b0;
  logic        reset;
  logic        run;
  logic        load_request;
  logic [9:0]  load_address;
  logic [31:0] load_data;
  logic        load_ack;
  logic        retire;
  logic [31:0] retire_pc;
  logic        writeback_enable;
  logic [4:0]  writeback_index;
  logic [31:0] writeback_data;
  logic        overflow;
  logic        store_strobe;
  logic [9:0]  store_address;
  logic [31:0] store_data;

  logic [31:0] program_words [$];
  logic [41:0] store_queue [$];
  logic [31:0] model_regs [0:31];
  logic [31:0] model_mem [0:1023];
  int          mismatch_count = 0;
  int          failure_count = 0;
  int          retire_count = 0;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  integer      seed = 32'h1b1a_2569;

  always #20 clock = ~clock;

  core_top core_top_inst (.*);

  function automatic logic [31:0] encode_basic(logic [4:0] sub5, logic [4:0] rt,
                                               logic [4:0] ra, logic [4:0] rb);
    return {1'b0, core_pkg::type_basic, rt, ra, rb, 5'd0, sub5};
  endfunction

  function automatic logic [31:0] encode_imm(logic [5:0] op, logic [4:0] rt,
                                             logic [4:0] ra, logic [14:0] imm);
    return {1'b0, op, rt, ra, imm};
  endfunction

  function automatic logic [31:0] encode_ls(logic [7:0] sub8, logic [4:0] rt, logic [4:0] ra,
                                            logic [4:0] rb, logic [1:0] sv);
    return {1'b0, core_pkg::type_ls, rt, ra, rb, sv, sub8};
  endfunction

  task automatic compare_value(string name, logic [31:0] actual, logic [31:0] expected);
    assert (actual === expected) else begin
      $display("MISMATCH %s: got %h, expected %h", name, actual, expected);
      mismatch_count++;
    end
  endtask

  // signed overflow when the 64-bit sum no longer fits in 32 bits
  function automatic logic signed_overflow(logic [31:0] a, logic [31:0] b, logic subtract);
    logic [63:0] wide_a;
    logic [63:0] wide_b;
    logic [63:0] total;
    wide_a = {{32{a[31]}}, a};
    wide_b = {{32{b[31]}}, b};
    total = subtract ? wide_a - wide_b : wide_a + wide_b;
    return total[63:31] != {33{total[31]}};
  endfunction

  task automatic check_retire();
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] simm;
    logic [31:0] result;
    logic [31:0] address;
    logic [41:0] entry;
    logic [4:0]  rt;
    logic [4:0]  shift;
    logic        writes;
    logic        stores;
    logic        expect_overflow;
    compare_value("retire_pc", retire_pc, retire_count * 4);
    if (retire_count >= program_words.size()) begin
      $display("retire seen beyond the end of the program");
      failure_count++;
      return;
    end
    instr = program_words[retire_count];
    rt = instr[24:20];
    a = model_regs[instr[19:15]];
    b = model_regs[instr[14:10]];
    simm = {{17{instr[14]}}, instr[14:0]};
    shift = b[4:0];
    result = '0;
    address = '0;
    writes = 1'b1;
    stores = 1'b0;
    expect_overflow = 1'b0;
    case (instr[30:25])
      core_pkg::type_basic: begin
        case (instr[4:0])
          core_pkg::add: begin
            result = a + b;
            expect_overflow = signed_overflow(a, b, 1'b0);
          end
          core_pkg::sub: begin
            result = a - b;
            expect_overflow = signed_overflow(a, b, 1'b1);
          end
          core_pkg::and_op: result = a & b;
          core_pkg::or_op:  result = a | b;
          core_pkg::xor_op: result = a ^ b;
          core_pkg::slli:   result = a << shift;
          core_pkg::srli:   result = (shift == 5'd0) ? 32'd0 : a >> shift;
          core_pkg::rotri:  result = (shift == 5'd0) ? a : (a >> shift) | (a << (6'd32 - shift));
          default:          writes = 1'b0;
        endcase
      end
      core_pkg::addi: begin
        result = a + simm;
        expect_overflow = signed_overflow(a, simm, 1'b0);
      end
      core_pkg::ori:  result = a | {17'd0, instr[14:0]};
      core_pkg::xori: result = a ^ {17'd0, instr[14:0]};
      core_pkg::movi: result = simm;
      core_pkg::lwi: begin
        address = a + (simm << 2);
        result = model_mem[address[11:2]];
      end
      core_pkg::swi: begin
        address = a + (simm << 2);
        writes = 1'b0;
        stores = 1'b1;
      end
      core_pkg::type_ls: begin
        if (instr[7:0] == core_pkg::lw) begin
          address = a + (b << instr[9:8]);
          result = model_mem[address[11:2]];
        end else begin
          // port b reads rt for a store, so rt is also the scaled index
          address = a + (model_regs[rt] << instr[9:8]);
          writes = 1'b0;
          stores = 1'b1;
        end
      end
      default: writes = 1'b0;
    endcase
    compare_value("writeback_enable", {31'd0, writeback_enable}, {31'd0, writes});
    compare_value("overflow", {31'd0, overflow}, {31'd0, expect_overflow});
    if (writes) begin
      compare_value("writeback_index", {27'd0, writeback_index}, {27'd0, rt});
      compare_value("writeback_data", writeback_data, result);
      if (rt != 5'd0) model_regs[rt] = result;
    end
    if (stores) begin
      if (store_queue.size() == 0) begin
        $display("store retired at pc %h without a store strobe", retire_pc);
        failure_count++;
      end else begin
        entry = store_queue.pop_front();
        compare_value("store_address", {22'd0, entry[41:32]}, {22'd0, address[11:2]});
        compare_value("store_data", entry[31:0], model_regs[rt]);
      end
      model_mem[address[11:2]] = model_regs[rt];
    end
    retire_count++;
  endtask

  // outputs sampled mid-cycle, away from the driving edge
  always @(negedge clock) begin
    if (!reset) begin
      if (store_strobe) store_queue.push_back({store_address, store_data});
      if (retire) check_retire();
    end
  end

  always @(posedge clock) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("timeout: no completion within %0d cycles", cycle_limit);
      $display("Result: FAILED");
      $finish;
    end
  end

  task automatic load_word(logic [9:0] address, logic [31:0] value);
    @(posedge clock);
    load_request <= 1'b1;
    load_address <= address;
    load_data    <= value;
    @(negedge clock);
    if (load_ack) begin
      $display("load_ack arrived in the same cycle as its request");
      failure_count++;
    end
    while (!load_ack) @(negedge clock);
    @(posedge clock);
    load_request <= 1'b0;
    model_mem[address] = value;
  endtask

  task automatic wait_retires(int count);
    while (retire_count < count) @(posedge clock);
  endtask

  task automatic build_program();
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = $random(seed);
    r2 = $random(seed);
    program_words.push_back(encode_imm(core_pkg::movi, 5'd1, 5'd0, r1[14:0]));
    program_words.push_back(encode_imm(core_pkg::movi, 5'd2, 5'd0, r2[14:0]));
    program_words.push_back(encode_basic(core_pkg::add, 5'd3, 5'd1, 5'd2));
    program_words.push_back(encode_basic(core_pkg::sub, 5'd4, 5'd1, 5'd2));
    program_words.push_back(encode_basic(core_pkg::and_op, 5'd5, 5'd1, 5'd2));
    program_words.push_back(encode_basic(core_pkg::or_op, 5'd6, 5'd1, 5'd2));
    program_words.push_back(encode_basic(core_pkg::xor_op, 5'd7, 5'd1, 5'd2));
    program_words.push_back(encode_imm(core_pkg::movi, 5'd8, 5'd0, 15'd5));
    program_words.push_back(encode_basic(core_pkg::slli, 5'd9, 5'd1, 5'd8));
    program_words.push_back(encode_basic(core_pkg::srli, 5'd10, 5'd1, 5'd8));
    program_words.push_back(encode_basic(core_pkg::srli, 5'd11, 5'd1, 5'd0));
    program_words.push_back(encode_basic(core_pkg::rotri, 5'd12, 5'd1, 5'd8));
    // operand pairs that overflow
    program_words.push_back(encode_imm(core_pkg::movi, 5'd13, 5'd0, 15'd30));
    program_words.push_back(encode_imm(core_pkg::movi, 5'd14, 5'd0, 15'd1));
    program_words.push_back(encode_basic(core_pkg::slli, 5'd15, 5'd14, 5'd13));
    program_words.push_back(encode_basic(core_pkg::add, 5'd16, 5'd15, 5'd15));
    program_words.push_back(encode_imm(core_pkg::movi, 5'd17, 5'd0, 15'd31));
    program_words.push_back(encode_basic(core_pkg::slli, 5'd18, 5'd14, 5'd17));
    program_words.push_back(encode_basic(core_pkg::sub, 5'd19, 5'd18, 5'd14));
    program_words.push_back(encode_imm(core_pkg::addi, 5'd20, 5'd19, 15'd1));
    program_words.push_back(encode_imm(core_pkg::addi, 5'd21, 5'd1, 15'h7ffb));
    program_words.push_back(encode_imm(core_pkg::ori, 5'd22, 5'd2, 15'h7abc));
    program_words.push_back(encode_imm(core_pkg::xori, 5'd23, 5'd1, 15'h4321));
    program_words.push_back(encode_imm(core_pkg::movi, 5'd24, 5'd0, 15'h7f9c));
    // stores into words 257 to 266
    program_words.push_back(encode_imm(core_pkg::movi, 5'd25, 5'd0, 15'd1024));
    program_words.push_back(encode_imm(core_pkg::movi, 5'd26, 5'd0, 15'd4));
    program_words.push_back(encode_imm(core_pkg::swi, 5'd3, 5'd25, 15'd10));
    program_words.push_back(encode_ls(core_pkg::sw, 5'd26, 5'd25, 5'd26, 2'd0));
    program_words.push_back(encode_ls(core_pkg::sw, 5'd26, 5'd25, 5'd26, 2'd1));
    program_words.push_back(encode_ls(core_pkg::sw, 5'd26, 5'd25, 5'd26, 2'd2));
    program_words.push_back(encode_ls(core_pkg::sw, 5'd26, 5'd25, 5'd26, 2'd3));
    program_words.push_back(encode_imm(core_pkg::lwi, 5'd27, 5'd25, 15'd10));
    program_words.push_back(encode_ls(core_pkg::lw, 5'd28, 5'd25, 5'd26, 2'd1));
    program_words.push_back(encode_imm(core_pkg::movi, 5'd29, 5'd0, 15'd2048));
    program_words.push_back(encode_imm(core_pkg::lwi, 5'd30, 5'd29, 15'd3));
    program_words.push_back(encode_ls(core_pkg::lw, 5'd31, 5'd29, 5'd26, 2'd2));
    program_words.push_back(encode_ls(core_pkg::lw, 5'd1, 5'd25, 5'd26, 2'd0));
  endtask

  initial begin
    logic [31:0] value;
    reset        = 1'b1;
    run          = 1'b0;
    load_request = 1'b0;
    load_address = '0;
    load_data    = '0;
    for (int i = 0; i < 32; i++) model_regs[i] = '0;
    build_program();
    cycle_limit = program_words.size() * 20 + (program_words.size() + data_words + 1) * 4 + 150;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    for (int i = 0; i < program_words.size(); i++) begin
      load_word(10'(i), program_words[i]);
    end
    for (int i = 0; i < data_words; i++) begin
      value = $random(seed);
      load_word(10'(data_base + i), value);
    end
    @(posedge clock);
    run <= 1'b1;
    // a load while the core fetches, the loader has priority
    value = $random(seed);
    load_word(10'(data_base + data_words), value);
    // drop run mid program, one more instruction may finish
    wait_retires(stop_at + 1);
    run <= 1'b0;
    repeat (30) @(posedge clock);
    if (retire_count != stop_at + 2) begin
      $display("core did not stop after one further retire, %0d retires seen", retire_count);
      failure_count++;
    end
    run <= 1'b1;
    wait_retires(program_words.size() - 1);
    run <= 1'b0;
    repeat (30) @(posedge clock);
    if (retire_count != program_words.size()) begin
      $display("program ended with %0d retires instead of %0d", retire_count,
               program_words.size());
      failure_count++;
    end
    if (store_queue.size() != 0) begin
      $display("store strobes seen without a retiring store");
      failure_count++;
    end
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== test/core_assertions.sv ====
`timescale 1ns/1ps

module core_assertions (
  input logic clock,
  input logic reset,
  input logic load_request,
  input logic load_ack,
  input logic data_ack,
  input logic fetch_ack,
  input logic retire,
  input logic writeback_enable,
  input logic store_strobe
);

  // at most one requester acknowledged per cycle
  acks_exclusive: assert property (
    @(posedge clock) disable iff (reset)
    $onehot0({load_ack, data_ack, fetch_ack})
  ) else $error("more than one memory ack in the same cycle");

  retire_single_cycle: assert property (
    @(posedge clock) disable iff (reset)
    retire |=> !retire
  ) else $error("retire stayed high for more than one cycle");

  // registered controls settle low under reset and stay low one cycle after
  controls_low_after_reset: assert property (
    @(posedge clock)
    reset |=> (!retire && !writeback_enable && !store_strobe && !load_ack)
  ) else $error("control output high during or just after reset");

  // the loader outranks fetch, so a pending load blocks the next fetch grant
  fetch_not_during_load: assert property (
    @(posedge clock) disable iff (reset)
    load_request |=> !fetch_ack
  ) else $error("fetch ack right after a cycle with a pending load");

endmodule

bind core_top core_assertions core_assertions_inst (.*);

// ==== design/core_top.sv ====
`timescale 1ns/1ps

module core_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        run,
  input  logic        load_request,
  input  logic [9:0]  load_address,
  input  logic [31:0] load_data,
  output logic        load_ack,
  output logic        retire,
  output logic [31:0] retire_pc,
  output logic        writeback_enable,
  output logic [4:0]  writeback_index,
  output logic [31:0] writeback_data,
  output logic        overflow,
  output logic        store_strobe,
  output logic [9:0]  store_address,
  output logic [31:0] store_data
);

  core_pkg::opcode_e   opcode;
  core_pkg::basic_op_e sub5;
  core_pkg::ls_op_e    sub8;
  logic [1:0]  sv;
  logic [4:0]  index_a;
  logic [4:0]  index_b;
  logic [4:0]  dest_index;
  logic        use_immediate;
  logic [31:0] immediate;
  logic        is_load;
  logic        is_store;
  logic        writes_register;
  logic [31:0] instruction;
  logic [31:0] read_data_a;
  logic [31:0] read_data_b;
  logic [31:0] alu_operand_b;
  logic [31:0] alu_result;
  logic        alu_overflow;
  logic        fetch_request;
  logic        fetch_ack;
  logic [9:0]  fetch_address;
  logic [31:0] fetch_data;
  logic        mem_start;
  logic        mem_is_store;
  logic [9:0]  mem_address;
  logic [31:0] mem_store_data;
  logic        mem_done;
  logic [31:0] mem_load_data;
  logic        data_request;
  logic        data_write;
  logic        data_ack;
  logic [31:0] data_read_data;
  logic        ram_enable;
  logic        ram_write;
  logic [9:0]  ram_address;
  logic [31:0] ram_write_data;
  logic [31:0] ram_read_data;

  // second ALU operand
  assign alu_operand_b = use_immediate ? immediate : read_data_b;

  instruction_sequencer instruction_sequencer_inst (
    .clock, .reset, .run, .fetch_ack, .fetch_data,
    .is_load, .is_store, .writes_register, .dest_index,
    .alu_result, .alu_overflow, .read_data_b, .mem_done, .mem_load_data,
    .fetch_request, .fetch_address, .instruction,
    .mem_start, .mem_is_store, .mem_address, .mem_store_data,
    .retire, .retire_pc, .writeback_enable, .writeback_index, .writeback_data, .overflow
  );

  instruction_decoder instruction_decoder_inst (
    .instruction, .opcode, .sub5, .sub8, .sv, .index_a, .index_b, .dest_index,
    .use_immediate, .immediate, .is_load, .is_store, .writes_register
  );

  register_file register_file_inst (
    .clock, .reset,
    .read_index_a (index_a),
    .read_index_b (index_b),
    .write_enable (writeback_enable),
    .write_index  (writeback_index),
    .write_data   (writeback_data),
    .read_data_a, .read_data_b
  );

  alu32 alu32_inst (
    .opcode,
    .sub_opcode_5bit (sub5),
    .sub_opcode_8bit (sub8),
    .scr1            (read_data_a),
    .scr2            (alu_operand_b),
    .sv, .alu_result, .alu_overflow
  );

  // store address and data are the data port's own outputs
  load_store_unit load_store_unit_inst (
    .clock, .reset, .mem_start, .mem_is_store, .mem_address, .mem_store_data,
    .data_ack, .data_read_data, .data_request, .data_write,
    .data_address    (store_address),
    .data_write_data (store_data),
    .mem_done, .mem_load_data
  );

  memory_arbiter memory_arbiter_inst (
    .clock, .reset,
    .load_request, .load_write (1'b1), .load_address,
    .load_write_data (load_data),
    .load_ack,
    .data_request, .data_write,
    .data_address    (store_address),
    .data_write_data (store_data),
    .data_ack, .data_read_data,
    .fetch_request, .fetch_address, .fetch_ack,
    .fetch_read_data (fetch_data),
    .mem_enable      (ram_enable),
    .mem_write       (ram_write),
    .mem_address     (ram_address),
    .mem_write_data  (ram_write_data),
    .mem_read_data   (ram_read_data),
    .store_strobe
  );

  shared_memory shared_memory_inst (
    .clock,
    .mem_enable     (ram_enable),
    .mem_write      (ram_write),
    .mem_address    (ram_address),
    .mem_write_data (ram_write_data),
    .mem_read_data  (ram_read_data)
  );

endmodule

// ==== design/shared_memory.sv ====
`timescale 1ns/1ps

module shared_memory (
  input  logic                               clock,
  input  logic                               mem_enable,
  input  logic                               mem_write,
  input  logic [core_pkg::mem_addr_width-1:0] mem_address,
  input  logic [31:0]                        mem_write_data,
  output logic [31:0]                        mem_read_data
);

  logic [31:0] storage [0:core_pkg::mem_words-1];

  // read data lands one cycle after the access
  always_ff @(posedge clock) begin
    if (mem_enable) begin
      if (mem_write) begin
        storage[mem_address] <= mem_write_data;
      end else begin
        mem_read_data <= storage[mem_address];
      end
    end
  end

endmodule

// ==== design/memory_arbiter.sv ====
`timescale 1ns/1ps

module memory_arbiter (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               load_request,
  input  logic                               load_write,
  input  logic [core_pkg::mem_addr_width-1:0] load_address,
  input  logic [31:0]                        load_write_data,
  output logic                               load_ack,
  input  logic                               data_request,
  input  logic                               data_write,
  input  logic [core_pkg::mem_addr_width-1:0] data_address,
  input  logic [31:0]                        data_write_data,
  output logic                               data_ack,
  output logic [31:0]                        data_read_data,
  input  logic                               fetch_request,
  input  logic [core_pkg::mem_addr_width-1:0] fetch_address,
  output logic                               fetch_ack,
  output logic [31:0]                        fetch_read_data,
  output logic                               mem_enable,
  output logic                               mem_write,
  output logic [core_pkg::mem_addr_width-1:0] mem_address,
  output logic [31:0]                        mem_write_data,
  input  logic [31:0]                        mem_read_data,
  output logic                               store_strobe
);

  logic busy;
  logic grant_load;
  logic grant_data;
  logic grant_fetch;

  // an ack in flight means an access is outstanding
  assign busy        = load_ack | data_ack | fetch_ack;
  assign grant_load  = !busy && load_request;
  assign grant_data  = !busy && !load_request && data_request;
  assign grant_fetch = !busy && !load_request && !data_request && fetch_request;

  assign mem_enable     = grant_load | grant_data | grant_fetch;
  assign mem_write      = (grant_load && load_write) || (grant_data && data_write);
  assign mem_address    = grant_load ? load_address :
                          grant_data ? data_address : fetch_address;
  assign mem_write_data = grant_load ? load_write_data : data_write_data;
  assign store_strobe   = grant_data && data_write;

  always_ff @(posedge clock) begin
    if (reset) begin
      load_ack  <= 1'b0;
      data_ack  <= 1'b0;
      fetch_ack <= 1'b0;
    end else begin
      load_ack  <= grant_load;
      data_ack  <= grant_data;
      fetch_ack <= grant_fetch;
    end
  end

  assign data_read_data  = data_ack ? mem_read_data : '0;
  assign fetch_read_data = fetch_ack ? mem_read_data : '0;

endmodule

// ==== design/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               mem_start,
  input  logic                               mem_is_store,
  input  logic [core_pkg::mem_addr_width-1:0] mem_address,
  input  logic [31:0]                        mem_store_data,
  input  logic                               data_ack,
  input  logic [31:0]                        data_read_data,
  output logic                               data_request,
  output logic                               data_write,
  output logic [core_pkg::mem_addr_width-1:0] data_address,
  output logic [31:0]                        data_write_data,
  output logic                               mem_done,
  output logic [31:0]                        mem_load_data
);

  // request held as a level until the arbiter acks
  always_ff @(posedge clock) begin
    if (reset) begin
      data_request <= 1'b0;
      mem_done     <= 1'b0;
    end else begin
      mem_done <= data_ack;
      if (mem_start) begin
        data_request <= 1'b1;
      end else if (data_ack) begin
        data_request <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (mem_start) begin
      data_write      <= mem_is_store;
      data_address    <= mem_address;
      data_write_data <= mem_store_data;
    end
    if (data_ack) begin
      mem_load_data <= data_read_data;
    end
  end

endmodule

// ==== design/instruction_sequencer.sv ====
`timescale 1ns/1ps

module instruction_sequencer (
  input  logic        clock,
  input  logic        reset,
  input  logic        run,
  input  logic        fetch_ack,
  input  logic [31:0] fetch_data,
  input  logic        is_load,
  input  logic        is_store,
  input  logic        writes_register,
  input  logic [4:0]  dest_index,
  input  logic [31:0] alu_result,
  input  logic        alu_overflow,
  input  logic [31:0] read_data_b,
  input  logic        mem_done,
  input  logic [31:0] mem_load_data,
  output logic        fetch_request,
  output logic [9:0]  fetch_address,
  output logic [31:0] instruction,
  output logic        mem_start,
  output logic        mem_is_store,
  output logic [9:0]  mem_address,
  output logic [31:0] mem_store_data,
  output logic        retire,
  output logic [31:0] retire_pc,
  output logic        writeback_enable,
  output logic [4:0]  writeback_index,
  output logic [31:0] writeback_data,
  output logic        overflow
);

  core_pkg::seq_state_e state;
  logic [31:0]          pc;

  assign fetch_request = (state == core_pkg::fetch);
  assign fetch_address = pc[core_pkg::mem_addr_width+1:2];

  always_ff @(posedge clock) begin
    if (reset) begin
      state            <= core_pkg::idle;
      pc               <= '0;
      mem_start        <= 1'b0;
      retire           <= 1'b0;
      writeback_enable <= 1'b0;
      overflow         <= 1'b0;
    end else begin
      mem_start        <= 1'b0;
      retire           <= 1'b0;
      writeback_enable <= 1'b0;
      case (state)
        core_pkg::idle: begin
          if (run) state <= core_pkg::fetch;
        end
        core_pkg::fetch: begin
          if (fetch_ack) state <= core_pkg::execute;
        end
        core_pkg::execute: begin
          overflow <= alu_overflow;
          if (is_load || is_store) begin
            state     <= core_pkg::memory;
            mem_start <= 1'b1;
          end else begin
            state            <= core_pkg::retire;
            retire           <= 1'b1;
            writeback_enable <= writes_register;
          end
        end
        core_pkg::memory: begin
          if (mem_done) begin
            state            <= core_pkg::retire;
            retire           <= 1'b1;
            writeback_enable <= writes_register;
          end
        end
        core_pkg::retire: begin
          pc    <= pc + 32'd4;
          // a low run parks the core after this instruction
          state <= run ? core_pkg::fetch : core_pkg::idle;
        end
        default: state <= core_pkg::idle;
      endcase
    end
  end

  // instruction and result payload
  always_ff @(posedge clock) begin
    if ((state == core_pkg::fetch) && fetch_ack) begin
      instruction <= fetch_data;
    end
    if (state == core_pkg::execute) begin
      mem_is_store    <= is_store;
      mem_address     <= alu_result[core_pkg::mem_addr_width+1:2];
      mem_store_data  <= read_data_b;
      writeback_data  <= alu_result;
      writeback_index <= dest_index;
      retire_pc       <= pc;
    end
    if ((state == core_pkg::memory) && mem_done && is_load) begin
      writeback_data <= mem_load_data;
    end
  end

endmodule

// ==== design/instruction_decoder.sv ====
`timescale 1ns/1ps

module instruction_decoder (
  input  logic [31:0]         instruction,
  output core_pkg::opcode_e   opcode,
  output core_pkg::basic_op_e sub5,
  output core_pkg::ls_op_e    sub8,
  output logic [1:0]          sv,
  output logic [4:0]          index_a,
  output logic [4:0]          index_b,
  output logic [4:0]          dest_index,
  output logic                use_immediate,
  output logic [31:0]         immediate,
  output logic                is_load,
  output logic                is_store,
  output logic                writes_register
);

  logic [4:0]  rt_field;
  logic [4:0]  rb_field;
  logic [14:0] imm15;
  logic        basic_defined;

  assign opcode   = core_pkg::opcode_e'(instruction[core_pkg::opcode_msb:core_pkg::opcode_lsb]);
  assign sub5     = core_pkg::basic_op_e'(instruction[core_pkg::sub5_msb:0]);
  assign sub8     = core_pkg::ls_op_e'(instruction[core_pkg::sub8_msb:0]);
  assign sv       = instruction[core_pkg::sv_msb:core_pkg::sv_lsb];
  assign rt_field = instruction[core_pkg::rt_msb:core_pkg::rt_lsb];
  assign rb_field = instruction[core_pkg::rb_msb:core_pkg::rb_lsb];
  assign imm15    = instruction[core_pkg::imm_msb:0];
  assign index_a  = instruction[core_pkg::ra_msb:core_pkg::ra_lsb];

  assign dest_index = rt_field;

  assign basic_defined = (sub5 inside {core_pkg::add, core_pkg::sub, core_pkg::and_op,
                                       core_pkg::or_op, core_pkg::xor_op, core_pkg::slli,
                                       core_pkg::srli, core_pkg::rotri});

  always_comb begin
    index_b         = rb_field;
    use_immediate   = 1'b0;
    immediate       = {{(31 - core_pkg::imm_msb){imm15[14]}}, imm15};
    is_load         = 1'b0;
    is_store        = 1'b0;
    writes_register = 1'b0;
    case (opcode)
      core_pkg::type_basic: writes_register = basic_defined;
      core_pkg::addi,
      core_pkg::movi: begin
        use_immediate   = 1'b1;
        writes_register = 1'b1;
      end
      // logic immediates are zero extended
      core_pkg::ori,
      core_pkg::xori: begin
        use_immediate   = 1'b1;
        immediate       = {17'd0, imm15};
        writes_register = 1'b1;
      end
      core_pkg::lwi: begin
        use_immediate   = 1'b1;
        is_load         = 1'b1;
        writes_register = 1'b1;
      end
      core_pkg::swi: begin
        use_immediate = 1'b1;
        is_store      = 1'b1;
        index_b       = rt_field;
      end
      core_pkg::type_ls: begin
        if (sub8 == core_pkg::lw) begin
          is_load         = 1'b1;
          writes_register = 1'b1;
        end else if (sub8 == core_pkg::sw) begin
          // port b reads the stored register, rt
          is_store = 1'b1;
          index_b  = rt_field;
        end
      end
      default: writes_register = 1'b0;
    endcase
  end

endmodule

// ==== design/register_file.sv ====
`timescale 1ns/1ps

module register_file (
  input  logic        clock,
  input  logic        reset,
  input  logic [4:0]  read_index_a,
  input  logic [4:0]  read_index_b,
  input  logic        write_enable,
  input  logic [4:0]  write_index,
  input  logic [31:0] write_data,
  output logic [31:0] read_data_a,
  output logic [31:0] read_data_b
);

  logic [31:0] registers [0:31];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        registers[i] <= '0;
      end
    end else if (write_enable && (write_index != 5'd0)) begin
      registers[write_index] <= write_data;
    end
  end

  // r0 is hardwired to zero
  assign read_data_a = (read_index_a == 5'd0) ? '0 : registers[read_index_a];
  assign read_data_b = (read_index_b == 5'd0) ? '0 : registers[read_index_b];

endmodule

// ==== design/alu32.sv ====
`timescale 1ns/1ps

module alu32 (
  input  core_pkg::opcode_e   opcode,
  input  core_pkg::basic_op_e sub_opcode_5bit,
  input  core_pkg::ls_op_e    sub_opcode_8bit,
  input  logic [31:0]         scr1,
  input  logic [31:0]         scr2,
  input  logic [1:0]          sv,
  output logic [31:0]         alu_result,
  output logic                alu_overflow
);

  logic [31:0] sum;
  logic [31:0] difference;
  logic [63:0] rotated;
  logic [4:0]  shift_amount;
  logic        add_overflow;
  logic        sub_overflow;

  assign shift_amount = scr2[4:0];
  assign sum          = scr1 + scr2;
  assign difference   = scr1 - scr2;
  assign rotated      = {scr1, scr1} >> shift_amount;

  // signed overflow: sign of result disagrees with the operands
  assign add_overflow = (scr1[31] == scr2[31]) && (sum[31] != scr1[31]);
  assign sub_overflow = (scr1[31] != scr2[31]) && (difference[31] != scr1[31]);

  always_comb begin
    alu_result   = '0;
    alu_overflow = 1'b0;
    case (opcode)
      core_pkg::type_basic: begin
        case (sub_opcode_5bit)
          core_pkg::add: begin
            alu_result   = sum;
            alu_overflow = add_overflow;
          end
          core_pkg::sub: begin
            alu_result   = difference;
            alu_overflow = sub_overflow;
          end
          core_pkg::and_op: alu_result = scr1 & scr2;
          core_pkg::or_op:  alu_result = scr1 | scr2;
          core_pkg::xor_op: alu_result = scr1 ^ scr2;
          // shift by zero yields zero here
          core_pkg::srli:   alu_result = (shift_amount == 5'd0) ? '0 : scr1 >> shift_amount;
          core_pkg::slli:   alu_result = scr1 << shift_amount;
          core_pkg::rotri:  alu_result = rotated[31:0];
          default:          alu_result = '0;
        endcase
      end
      core_pkg::addi: begin
        alu_result   = sum;
        alu_overflow = add_overflow;
      end
      core_pkg::ori:  alu_result = scr1 | scr2;
      core_pkg::xori: alu_result = scr1 ^ scr2;
      core_pkg::movi: alu_result = scr2;
      // byte addresses, word offset scaled by 4
      core_pkg::lwi,
      core_pkg::swi:  alu_result = scr1 + (scr2 << 2);
      core_pkg::type_ls: begin
        case (sub_opcode_8bit)
          core_pkg::lw,
          core_pkg::sw: alu_result = scr1 + (scr2 << sv);
          default:      alu_result = '0;
        endcase
      end
      default: alu_result = '0;
    endcase
  end

endmodule

// ==== design/core_pkg.sv ====
package core_pkg;

  // major opcode, bits 30..25
  typedef enum logic [5:0] {
    type_basic = 6'b100000,
    addi       = 6'b101000,
    ori        = 6'b101100,
    xori       = 6'b101011,
    movi       = 6'b100010,
    lwi        = 6'b000010,
    swi        = 6'b001010,
    type_ls    = 6'b011100
  } opcode_e;

  // sub-opcode of type_basic
  typedef enum logic [4:0] {
    add    = 5'b00000,
    sub    = 5'b00001,
    and_op = 5'b00010,
    xor_op = 5'b00011,
    or_op  = 5'b00100,
    slli   = 5'b01000,
    srli   = 5'b01001,
    rotri  = 5'b01011
  } basic_op_e;

  // sub-opcode of type_ls
  typedef enum logic [7:0] {
    lw = 8'b00000010,
    sw = 8'b00001010
  } ls_op_e;

  typedef enum logic [2:0] {
    idle,
    fetch,
    execute,
    memory,
    retire
  } seq_state_e;

  // instruction field positions
  localparam int opcode_msb = 30;
  localparam int opcode_lsb = 25;
  localparam int rt_msb     = 24;
  localparam int rt_lsb     = 20;
  localparam int ra_msb     = 19;
  localparam int ra_lsb     = 15;
  localparam int rb_msb     = 14;
  localparam int rb_lsb     = 10;
  localparam int sv_msb     = 9;
  localparam int sv_lsb     = 8;
  localparam int sub8_msb   = 7;
  localparam int sub5_msb   = 4;
  localparam int imm_msb    = 14;

  localparam int mem_words      = 1024;
  localparam int mem_addr_width = 10;

endpackage
